// File: source/dist_pkg.sv
package dist_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	// default payload width
	// also the width of the word struct payload
	parameter int DATA_WIDTH_DEF = 32;

	// default tree depth
	// 2 levels give 4 leaves
	parameter int LEVELS_DEF = 2;

	// width of each per-leaf delivery counter
	parameter int CNT_WIDTH = 8;

	////////////////////////////////////////////////////////////////////////////
	// switch commands
	////////////////////////////////////////////////////////////////////////////

	// bit 0 selects the low child, bit 1 the high child
	// so the encoder can build a command from two reduced mask halves
	typedef enum logic [1:0]
	{
		// word is dropped at this switch
		CMD_NONE = 2'b00,
		// forward to low child only
		CMD_LOW  = 2'b01,
		// forward to high child only
		CMD_HIGH = 2'b10,
		// copy to both children
		CMD_DUP  = 2'b11
	} dist_cmd_e;

	////////////////////////////////////////////////////////////////////////////
	// word and leaf payload
	////////////////////////////////////////////////////////////////////////////

	// one word in flight between the parts
	// valid in the top bit, payload below it
	// modules with DATA_WIDTH below the default use the low bits only
	typedef struct packed
	{
		logic                      valid;
		logic [DATA_WIDTH_DEF-1:0] data;
	} dist_word_t;

endpackage

// File: source/distribute_1x2_switch.sv
module distribute_1x2_switch #(
	parameter int DATA_WIDTH = dist_pkg::DATA_WIDTH_DEF
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_en,
	input  dist_pkg::dist_word_t i_word,
	input  dist_pkg::dist_cmd_e  i_cmd,
	output dist_pkg::dist_word_t o_low,
	output dist_pkg::dist_word_t o_high
);

	// branch selects from the command, before valid gating
	logic sel_low;
	logic sel_high;
	// branch selects qualified by the incoming valid
	logic go_low;
	logic go_high;
	// payload with bits above DATA_WIDTH forced to zero
	logic [dist_pkg::DATA_WIDTH_DEF-1:0] payload;

	////////////////////////////////////////////////////////////////////////////
	// command decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		sel_low = 1'b0;
		sel_high = 1'b0;
		case (i_cmd)
			dist_pkg::CMD_LOW:
			begin
				sel_low = 1'b1;
			end
			dist_pkg::CMD_HIGH:
			begin
				sel_high = 1'b1;
			end
			dist_pkg::CMD_DUP:
			begin
				sel_low = 1'b1;
				sel_high = 1'b1;
			end
			// CMD_NONE drops the word
			default:
			begin
				sel_low = 1'b0;
				sel_high = 1'b0;
			end
		endcase
	end

	// output valid needs both the command and a valid word
	assign go_low = sel_low & i_word.valid;
	assign go_high = sel_high & i_word.valid;

	always_comb
	begin
		payload = '0;
		payload[DATA_WIDTH-1:0] = i_word.data[DATA_WIDTH-1:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// output registers, one tree level
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_low <= '0;
			o_high <= '0;
		end
		else if (i_en)
		begin
			o_low.valid <= go_low;
			o_low.data <= go_low ? payload : '0;
			o_high.valid <= go_high;
			o_high.data <= go_high ? payload : '0;
		end
	end

endmodule

// File: source/dist_cmd_encoder.sv
module dist_cmd_encoder #(
	parameter int DATA_WIDTH = dist_pkg::DATA_WIDTH_DEF,
	parameter int LEVELS = dist_pkg::LEVELS_DEF,
	localparam int LEAVES = 2 ** LEVELS,
	localparam int NODES = LEAVES - 1
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                i_en,
	input  logic                                i_valid,
	input  logic [DATA_WIDTH-1:0]               i_data,
	input  logic [LEAVES-1:0]                   i_dest_mask,
	output dist_pkg::dist_word_t                o_root,
	output dist_pkg::dist_cmd_e [NODES-1:0]     o_cmds
);

	// commands for the word currently at the input, one per switch
	dist_pkg::dist_cmd_e [NODES-1:0] cmd_next;
	// input word widened into the struct payload field
	logic [dist_pkg::DATA_WIDTH_DEF-1:0] data_ext;
	// an empty mask reaches no leaf, so the word dies here
	logic root_valid;

	////////////////////////////////////////////////////////////////////////////
	// mask to per-switch commands
	////////////////////////////////////////////////////////////////////////////

	// heap order, node n at level k sits at index 2**k - 1 + position
	// each switch covers SPAN leaves, the lower HALF go to its low child
	for (genvar k = 0; k < LEVELS; k++)
	begin : g_level
		for (genvar p = 0; p < 2 ** k; p++)
		begin : g_node
			localparam int SPAN = 2 ** (LEVELS - k);
			localparam int HALF = SPAN / 2;
			localparam int NODE = 2 ** k - 1 + p;

			// high bit from the upper half, low bit from the lower half
			assign cmd_next[NODE] = dist_pkg::dist_cmd_e'({
				|i_dest_mask[p * SPAN + HALF +: HALF],
				|i_dest_mask[p * SPAN +: HALF]
			});
		end
	end

	// zero fill above the used payload bits
	always_comb
	begin
		data_ext = '0;
		data_ext[DATA_WIDTH-1:0] = i_data;
	end

	assign root_valid = i_valid & (|i_dest_mask);

	////////////////////////////////////////////////////////////////////////////
	// input register stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_root <= '0;
			for (int n = 0; n < NODES; n++)
			begin
				o_cmds[n] <= dist_pkg::CMD_NONE;
			end
		end
		else if (i_en)
		begin
			o_root.valid <= root_valid;
			// invalid words carry zero data into the tree
			o_root.data <= root_valid ? data_ext : '0;
			o_cmds <= cmd_next;
		end
	end

endmodule

// File: source/distribute_tree.sv
module distribute_tree #(
	parameter int DATA_WIDTH = dist_pkg::DATA_WIDTH_DEF,
	parameter int LEVELS = dist_pkg::LEVELS_DEF,
	localparam int LEAVES = 2 ** LEVELS,
	localparam int NODES = LEAVES - 1
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                i_en,
	input  dist_pkg::dist_word_t                i_root,
	input  dist_pkg::dist_cmd_e [NODES-1:0]     i_cmds,
	output dist_pkg::dist_word_t [LEAVES-1:0]   o_leaves
);

	// level k needs its commands k cycles late, level 0 uses them directly
	// so the delay line is LEVELS - 1 deep, at least one entry
	localparam int SR_DEPTH = (LEVELS > 1) ? LEVELS - 1 : 1;

	// cmd_sr[s] holds the command vector delayed by s + 1 cycles
	dist_pkg::dist_cmd_e [NODES-1:0] cmd_sr [SR_DEPTH];

	// every node input and leaf in heap order
	// index 0 is the root, children of n are 2n+1 (low) and 2n+2 (high)
	// leaves start at index NODES
	dist_pkg::dist_word_t [2*LEAVES-2:0] heap;

	////////////////////////////////////////////////////////////////////////////
	// command delay line
	////////////////////////////////////////////////////////////////////////////

	// moves with the words, so each word meets its own commands
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int s = 0; s < SR_DEPTH; s++)
			begin
				for (int n = 0; n < NODES; n++)
				begin
					cmd_sr[s][n] <= dist_pkg::CMD_NONE;
				end
			end
		end
		else if (i_en)
		begin
			cmd_sr[0] <= i_cmds;
			for (int s = 1; s < SR_DEPTH; s++)
			begin
				cmd_sr[s] <= cmd_sr[s-1];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// switch array
	////////////////////////////////////////////////////////////////////////////

	assign heap[0] = i_root;

	for (genvar k = 0; k < LEVELS; k++)
	begin : g_level
		for (genvar p = 0; p < 2 ** k; p++)
		begin : g_node
			localparam int NODE = 2 ** k - 1 + p;

			// command seen by this switch, aligned with its input word
			dist_pkg::dist_cmd_e node_cmd;

			if (k == 0)
			begin : g_direct
				assign node_cmd = i_cmds[NODE];
			end
			else
			begin : g_delayed
				assign node_cmd = cmd_sr[k-1][NODE];
			end

			distribute_1x2_switch #(
				.DATA_WIDTH (DATA_WIDTH)
			) switch_inst (
				.clk    (clk),
				.rst    (rst),
				.i_en   (i_en),
				.i_word (heap[NODE]),
				.i_cmd  (node_cmd),
				.o_low  (heap[2*NODE+1]),
				.o_high (heap[2*NODE+2])
			);
		end
	end

	// bottom row of the heap, leaf 0 first
	assign o_leaves = heap[2*LEAVES-2:NODES];

endmodule

// File: source/dist_egress.sv
module dist_egress #(
	parameter int DATA_WIDTH = dist_pkg::DATA_WIDTH_DEF,
	parameter int LEVELS = dist_pkg::LEVELS_DEF,
	localparam int LEAVES = 2 ** LEVELS
) (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        i_en,
	input  dist_pkg::dist_word_t [LEAVES-1:0]           i_leaves,
	output logic [LEAVES-1:0]                           o_leaf_valid,
	output logic [LEAVES-1:0][DATA_WIDTH-1:0]           o_leaf_data,
	output logic [LEAVES-1:0][dist_pkg::CNT_WIDTH-1:0]  o_leaf_count
);

	// counter ceiling, counts stick here
	localparam logic [dist_pkg::CNT_WIDTH-1:0] CNT_MAX = '1;

	// increment request per leaf, valid leaf and room left
	logic [LEAVES-1:0] cnt_inc;

	////////////////////////////////////////////////////////////////////////////
	// saturation check
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int l = 0; l < LEAVES; l++)
		begin
			cnt_inc[l] = i_leaves[l].valid & (o_leaf_count[l] != CNT_MAX);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// leaf registers and counters
	////////////////////////////////////////////////////////////////////////////

	// counter moves on the same edge as the leaf valid rises
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_leaf_valid <= '0;
			o_leaf_data <= '0;
			o_leaf_count <= '0;
		end
		else if (i_en)
		begin
			for (int l = 0; l < LEAVES; l++)
			begin
				o_leaf_valid[l] <= i_leaves[l].valid;
				// tree already zeroes invalid leaves
				o_leaf_data[l] <= i_leaves[l].data[DATA_WIDTH-1:0];
				if (cnt_inc[l])
				begin
					o_leaf_count[l] <= o_leaf_count[l] + 1'b1;
				end
			end
		end
	end

endmodule

// File: source/dist_top.sv
module dist_top #(
	parameter int DATA_WIDTH = dist_pkg::DATA_WIDTH_DEF,
	parameter int LEVELS = dist_pkg::LEVELS_DEF,
	localparam int LEAVES = 2 ** LEVELS,
	localparam int NODES = LEAVES - 1
) (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        i_en,
	input  logic                                        i_valid,
	input  logic [DATA_WIDTH-1:0]                       i_data,
	input  logic [LEAVES-1:0]                           i_dest_mask,
	output logic [LEAVES-1:0]                           o_leaf_valid,
	output logic [LEAVES-1:0][DATA_WIDTH-1:0]           o_leaf_data,
	output logic [LEAVES-1:0][dist_pkg::CNT_WIDTH-1:0]  o_leaf_count
);

	// encoder to tree
	dist_pkg::dist_word_t              root_word;
	dist_pkg::dist_cmd_e [NODES-1:0]   root_cmds;
	// tree to egress
	dist_pkg::dist_word_t [LEAVES-1:0] leaf_words;

	// input stage, 1 cycle
	dist_cmd_encoder #(
		.DATA_WIDTH (DATA_WIDTH),
		.LEVELS     (LEVELS)
	) dist_cmd_encoder_inst (
		.clk         (clk),
		.rst         (rst),
		.i_en        (i_en),
		.i_valid     (i_valid),
		.i_data      (i_data),
		.i_dest_mask (i_dest_mask),
		.o_root      (root_word),
		.o_cmds      (root_cmds)
	);

	// switch tree, LEVELS cycles
	distribute_tree #(
		.DATA_WIDTH (DATA_WIDTH),
		.LEVELS     (LEVELS)
	) distribute_tree_inst (
		.clk      (clk),
		.rst      (rst),
		.i_en     (i_en),
		.i_root   (root_word),
		.i_cmds   (root_cmds),
		.o_leaves (leaf_words)
	);

	// output stage, 1 cycle
	dist_egress #(
		.DATA_WIDTH (DATA_WIDTH),
		.LEVELS     (LEVELS)
	) dist_egress_inst (
		.clk          (clk),
		.rst          (rst),
		.i_en         (i_en),
		.i_leaves     (leaf_words),
		.o_leaf_valid (o_leaf_valid),
		.o_leaf_data  (o_leaf_data),
		.o_leaf_count (o_leaf_count)
	);

endmodule

// File: testbench/dist_props.sv
module dist_props #(
	parameter int DATA_WIDTH = dist_pkg::DATA_WIDTH_DEF,
	parameter int LEVELS = dist_pkg::LEVELS_DEF,
	localparam int LEAVES = 2 ** LEVELS,
	localparam int DEPTH = LEVELS + 2
) (
	input logic                                        clk,
	input logic                                        rst,
	input logic                                        i_en,
	input logic                                        i_valid,
	input logic [DATA_WIDTH-1:0]                       i_data,
	input logic [LEAVES-1:0]                           i_dest_mask,
	input logic [LEAVES-1:0]                           i_leaf_valid,
	input logic [LEAVES-1:0][DATA_WIDTH-1:0]           i_leaf_data,
	input logic [LEAVES-1:0][dist_pkg::CNT_WIDTH-1:0]  i_leaf_count
);

	// one input word as it should look at the leaves
	typedef struct packed
	{
		// valid word with an empty mask, must vanish
		logic                  drop;
		// leaves the word must reach, zero when there is no word
		logic [LEAVES-1:0]     mask;
		logic [DATA_WIDTH-1:0] data;
	} shadow_t;

	// stage DEPTH-1 lines up with the leaf outputs
	shadow_t shadow [DEPTH];
	logic [LEAVES-1:0][dist_pkg::CNT_WIDTH-1:0] exp_count;
	logic [LEAVES-1:0][DATA_WIDTH-1:0] exp_data;
	// read by the testbench top
	int fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// shadow latency model
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int s = 0; s < DEPTH; s++)
			begin
				shadow[s] <= '0;
			end
			exp_count <= '0;
		end
		else if (i_en)
		begin
			shadow[0].drop <= i_valid & ~(|i_dest_mask);
			shadow[0].mask <= i_valid ? i_dest_mask : '0;
			shadow[0].data <= i_data;
			for (int s = 1; s < DEPTH; s++)
			begin
				shadow[s] <= shadow[s-1];
			end
			// counts move together with the word entering the last stage
			for (int l = 0; l < LEAVES; l++)
			begin
				if (shadow[DEPTH-2].mask[l] && exp_count[l] != {dist_pkg::CNT_WIDTH{1'b1}})
				begin
					exp_count[l] <= exp_count[l] + 1'b1;
				end
			end
		end
	end

	// invalid leaves carry zero
	always_comb
	begin
		for (int l = 0; l < LEAVES; l++)
		begin
			exp_data[l] = shadow[DEPTH-1].mask[l] ? shadow[DEPTH-1].data : '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// properties
	////////////////////////////////////////////////////////////////////////////

	reset_clears: assert property (@(posedge clk)
		rst |=> (i_leaf_valid == '0 && i_leaf_data == '0 && i_leaf_count == '0))
	else
	begin
		fail_count++;
		$error("Fail %0t: leaf outputs not cleared by reset", $time);
	end

	// routing: low, high and copy at every level
	leaf_routing: assert property (@(posedge clk) disable iff (rst)
		i_leaf_valid == shadow[DEPTH-1].mask)
	else
	begin
		fail_count++;
		$error("Fail %0t: leaf valid %b, expected %b", $time, i_leaf_valid,
			shadow[DEPTH-1].mask);
	end

	leaf_payload: assert property (@(posedge clk) disable iff (rst)
		i_leaf_data == exp_data)
	else
	begin
		fail_count++;
		$error("Fail %0t: leaf data does not match the input word", $time);
	end

	empty_mask_drops: assert property (@(posedge clk) disable iff (rst)
		shadow[DEPTH-1].drop |-> i_leaf_valid == '0)
	else
	begin
		fail_count++;
		$error("Fail %0t: word with empty mask reached a leaf", $time);
	end

	hold_on_stall: assert property (@(posedge clk) disable iff (rst)
		!i_en |=> $stable(i_leaf_valid) && $stable(i_leaf_data) && $stable(i_leaf_count))
	else
	begin
		fail_count++;
		$error("Fail %0t: outputs moved while enable was low", $time);
	end

	// saturating delivery counts
	leaf_counts: assert property (@(posedge clk) disable iff (rst)
		i_leaf_count == exp_count)
	else
	begin
		fail_count++;
		$error("Fail %0t: leaf counts %h, expected %h", $time, i_leaf_count, exp_count);
	end

endmodule

bind dist_top dist_props #(
	.DATA_WIDTH (DATA_WIDTH),
	.LEVELS     (LEVELS)
) dist_props_inst (
	.clk          (clk),
	.rst          (rst),
	.i_en         (i_en),
	.i_valid      (i_valid),
	.i_data       (i_data),
	.i_dest_mask  (i_dest_mask),
	.i_leaf_valid (o_leaf_valid),
	.i_leaf_data  (o_leaf_data),
	.i_leaf_count (o_leaf_count)
);

// File: testbench/dist_tb.sv
module dist_tb;

	localparam int DATA_WIDTH = dist_pkg::DATA_WIDTH_DEF;
	localparam int LEVELS = dist_pkg::LEVELS_DEF;
	localparam int LEAVES = 2 ** LEVELS;
	localparam int DEPTH = LEVELS + 2;
	localparam int RAND_CYCLES = 300;
	// enough all-ones words to pin every counter at its ceiling
	localparam int SAT_CYCLES = 2 ** dist_pkg::CNT_WIDTH + 4;
	localparam int DRAIN_TIMEOUT = 50;

	logic clk;
	logic rst;
	logic i_en;
	logic i_valid;
	logic [DATA_WIDTH-1:0] i_data;
	logic [LEAVES-1:0] i_dest_mask;
	logic [LEAVES-1:0] o_leaf_valid;
	logic [LEAVES-1:0][DATA_WIDTH-1:0] o_leaf_data;
	logic [LEAVES-1:0][dist_pkg::CNT_WIDTH-1:0] o_leaf_count;
	// stimulus generator state
	logic [15:0] lfsr_state;

	dist_top #(
		.DATA_WIDTH (DATA_WIDTH),
		.LEVELS     (LEVELS)
	) dist_top_inst (
		.clk          (clk),
		.rst          (rst),
		.i_en         (i_en),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.i_dest_mask  (i_dest_mask),
		.o_leaf_valid (o_leaf_valid),
		.o_leaf_data  (o_leaf_data),
		.o_leaf_count (o_leaf_count)
	);

	always #5 clk = ~clk;

	// right-shifting Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	// one LFSR step per bit
	task automatic take_bits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int b = 0; b < count; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", reason);
	endtask

	// new inputs land on the next rising edge
	task automatic send_word(input logic en, input logic valid, input logic [LEAVES-1:0] mask);
		logic [31:0] data;
		take_bits(DATA_WIDTH, data);
		@(posedge clk);
		i_en <= en;
		i_valid <= valid;
		i_dest_mask <= mask;
		i_data <= data[DATA_WIDTH-1:0];
	endtask

	// first property failure ends the run
	always @(negedge clk)
	begin
		if (dist_top_inst.dist_props_inst.fail_count != 0)
			abort_run("a property in dist_props failed");
	end

	initial
	begin
		logic [31:0] stall_bits;
		logic [31:0] valid_bits;
		logic [31:0] mask_bits;
		int quiet;
		int waited;
		clk = 1'b0;
		rst = 1'b1;
		i_en = 1'b0;
		i_valid = 1'b0;
		i_data = '0;
		i_dest_mask = '0;
		lfsr_state = 16'd78;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		////////////////////////////////////////////////////////////////////////////
		// directed masks, one leaf each, all leaves, none
		////////////////////////////////////////////////////////////////////////////
		for (int l = 0; l < LEAVES; l++)
			send_word(1'b1, 1'b1, LEAVES'(1) << l);
		send_word(1'b1, 1'b1, '1);
		send_word(1'b1, 1'b1, '0);

		////////////////////////////////////////////////////////////////////////////
		// random traffic, enable low about one cycle in eight
		////////////////////////////////////////////////////////////////////////////
		for (int c = 0; c < RAND_CYCLES; c++)
		begin
			take_bits(3, stall_bits);
			take_bits(2, valid_bits);
			take_bits(LEAVES, mask_bits);
			send_word(stall_bits[2:0] != 3'd0, valid_bits[1:0] != 2'd0,
				mask_bits[LEAVES-1:0]);
		end
		// broadcast burst drives every counter into saturation
		repeat (SAT_CYCLES) send_word(1'b1, 1'b1, '1);

		////////////////////////////////////////////////////////////////////////////
		// drain until the leaves stay quiet for a full pipeline depth
		////////////////////////////////////////////////////////////////////////////
		send_word(1'b1, 1'b0, '0);
		quiet = 0;
		waited = 0;
		while (quiet < DEPTH)
		begin
			@(negedge clk);
			waited++;
			quiet = (o_leaf_valid == '0) ? quiet + 1 : 0;
			if (waited > DRAIN_TIMEOUT)
				abort_run("timeout: leaf outputs did not drain");
		end
		@(negedge clk);

		if (dist_top_inst.dist_props_inst.fail_count != 0)
			abort_run("property failures were recorded");
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: list.f
source/dist_pkg.sv
source/distribute_1x2_switch.sv
source/dist_cmd_encoder.sv
source/distribute_tree.sv
source/dist_egress.sv
source/dist_top.sv
testbench/dist_props.sv
testbench/dist_tb.sv

// File: Bender.yml
package:
  name: dist_network

sources:
  # design, in compile order
  - target: rtl
    files:
      - source/dist_pkg.sv
      - source/distribute_1x2_switch.sv
      - source/dist_cmd_encoder.sv
      - source/distribute_tree.sv
      - source/dist_egress.sv
      - source/dist_top.sv

  # bound properties and testbench top
  - target: test
    files:
      - testbench/dist_props.sv
      - testbench/dist_tb.sv
